//--- build.f
design/rx_dma_pkg.sv
design/rx_byte_packer.sv
design/rx_pkt_framer.sv
design/rx_stream_buffer.sv
design/rx_dma_top.sv
test/rx_dma_tb.sv

//--- test/rx_dma_tb.sv
// testbench for rx_dma_top driving random packets through keep, drop, stall and recovery paths
`default_nettype none

module rx_dma_tb
    import rx_dma_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int NPKT = 15;
    localparam int EXP_MAX = 512;
    localparam int INTR_DLY = 12;
    localparam int TIMEOUT_LONG = 2000;
    localparam int HS_LIMIT = 200;
    localparam int KEEP = 0, DROP = 1, NO_DECISION = 2, LATE_KEEP = 3, UNSUPPORTED = 4;

    logic clk = 1'b0;
    logic rstn, sig_valid, ht_sgi, ht_aggr, ht_aggr_last, ht_unsupport;
    logic [LEN_W-1:0] pkt_len;
    logic [7:0] pkt_rate;
    logic [RSSI_W-1:0] rssi_half_db;
    logic [TSF_W-1:0] tsf_val;
    logic [BYTE_W-1:0] byte_data;
    logic byte_valid, byte_last, decision_req, decision_drop, decision_ack;
    logic us_tick, recover_en, out_ready, out_valid, out_last, tlast_recover, rx_pkt_intr;
    logic [TIMEOUT_W-1:0] timeout_top;
    logic [INTR_DELAY_W-1:0] intr_delay;
    logic [WORD_W-1:0] out_data;
    logic [WORDS_W-1:0] num_words;

    // reference model state
    logic [WORD_W-1:0] exp_data [EXP_MAX];
    logic exp_last [EXP_MAX];
    int wr_idx = 0, rd_idx = 0, delivered = 0, exp_num = 0;
    int lens [NPKT];
    int pkt_idx = 0, errors = 0, tests_ok = 0, tests_bad = 0, watchdog_cycles = 0;
    logic [31:0] rnd_state = 32'h450e, rdy_state = 32'h450e;
    logic bp_on = 1'b0, ack_allowed = 1'b0, recover_armed = 1'b0;
    int tick_cnt = 0;
    logic xfer, xfer_last;

    rx_dma_top u_dut (.*);

    always #10 clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    function logic [31:0] next_random();
        rnd_state = xorshift(rnd_state);
        return rnd_state;
    endfunction

    task automatic report_mismatch(input string msg);
        $display("CHECK FAILED at %0t: %s", $time, msg);
        errors++;
    endtask

    task automatic report_failure(input string msg);
        $display("ERROR at %0t: %s", $time, msg);
        errors++;
    endtask

    // us tick every 5 cycles and random ready only while back-pressure is on
    always @(negedge clk) begin
        tick_cnt = (tick_cnt == 4) ? 0 : tick_cnt + 1;
        us_tick = (tick_cnt == 0);
        rdy_state = xorshift(rdy_state);
        out_ready = bp_on ? rdy_state[3] : 1'b1;
    end

    assign xfer = rstn && out_valid && out_ready;
    assign xfer_last = xfer && out_last;

    always @(posedge clk) begin
        if (xfer) rd_idx <= rd_idx + 1;
        if (xfer_last) delivered <= delivered + 1;
    end

    a_word: assert property (@(posedge clk) disable iff (!rstn)
        xfer |-> out_data == exp_data[rd_idx] && out_last == exp_last[rd_idx])
        else report_mismatch($sformatf("word %0d got %h last %b", rd_idx, out_data, out_last));
    a_word_expected: assert property (@(posedge clk) disable iff (!rstn)
        out_valid |-> rd_idx < wr_idx)
        else report_mismatch("stream offers a word that the model does not expect");
    a_num_words: assert property (@(posedge clk) disable iff (!rstn)
        out_valid |-> num_words == exp_num)
        else report_mismatch($sformatf("num_words %0d, expected %0d", num_words, exp_num));
    a_stall_hold: assert property (@(posedge clk) disable iff (!rstn)
        out_valid && !out_ready |=> out_valid && $stable(out_data) && $stable(out_last))
        else report_mismatch("stream word changed while stalled");
    a_intr_after_last: assert property (@(posedge clk) disable iff (!rstn)
        $past(xfer_last, INTR_DLY + 1) |-> rx_pkt_intr)
        else report_mismatch("rx_pkt_intr missing after the last word");
    a_intr_timing: assert property (@(posedge clk) disable iff (!rstn)
        rx_pkt_intr |-> $past(xfer_last, INTR_DLY + 1))
        else report_mismatch("rx_pkt_intr is high at the wrong cycle");
    a_recover_pulse: assert property (@(posedge clk) disable iff (!rstn)
        tlast_recover |-> recover_armed)
        else report_mismatch("unexpected tlast_recover pulse");
    a_ack_allowed: assert property (@(posedge clk) disable iff (!rstn)
        decision_ack |-> ack_allowed)
        else report_mismatch("decision_ack raised without a pending decision");

    // four-phase keep or drop exchange
    task automatic decide(input logic drop);
        int t;
        ack_allowed = 1'b1;
        decision_drop = drop;
        decision_req = 1'b1;
        for (t = 0; t < HS_LIMIT && !decision_ack; t++) @(negedge clk);
        if (!decision_ack) report_failure("decision_ack did not rise after decision_req");
        decision_req = 1'b0;
        for (t = 0; t < HS_LIMIT && decision_ack; t++) @(negedge clk);
        if (decision_ack) report_failure("decision_ack stayed high after decision_req fell");
        ack_allowed = 1'b0;
        decision_drop = 1'b0;
    endtask

    task automatic send_packet(input int mode);
        logic [7:0] pay [200];
        logic [31:0] r;
        logic [WORD_W-1:0] info;
        int len, nw, t, target;
        len = lens[pkt_idx];
        pkt_idx++;
        r = next_random();
        nw = (len + 7) / 8 + HDR_WORDS;
        for (int b = 0; b < len; b++) pay[b] = 8'(next_random());
        sig_valid = 1'b1;
        pkt_len = LEN_W'(len);
        tsf_val = {next_random(), next_random()};
        {ht_aggr_last, ht_aggr, ht_sgi, pkt_rate, rssi_half_db} = r[21:0];
        ht_unsupport = (mode == UNSUPPORTED);
        if (mode == KEEP || mode == LATE_KEEP) begin
            info = '0;
            info[10:0] = rssi_half_db;
            info[47:32] = pkt_len;
            info[51:48] = pkt_rate[3:0];
            info[52] = pkt_rate[7];
            info[55:53] = {ht_aggr_last, ht_aggr, ht_sgi};
            exp_data[wr_idx] = tsf_val;
            exp_data[wr_idx + 1] = info;
            for (int k = 0; k < nw; k++) exp_last[wr_idx + k] = (k == nw - 1);
            for (int k = HDR_WORDS; k < nw; k++) exp_data[wr_idx + k] = '0;
            // byte i lands in lane i mod 8
            for (int b = 0; b < len; b++)
                exp_data[wr_idx + HDR_WORDS + b / 8][(b % 8) * 8 +: 8] = pay[b];
            exp_num = nw;
            wr_idx += nw;
        end
        @(negedge clk);
        sig_valid = 1'b0;
        repeat (3) @(negedge clk);
        for (int b = 0; b < len; b++) begin
            byte_data = pay[b];
            byte_valid = 1'b1;
            byte_last = (b == len - 1);
            @(negedge clk);
            byte_valid = 1'b0;
            byte_last = 1'b0;
            @(negedge clk);
        end
        target = delivered + 1;
        if (mode == LATE_KEEP) repeat (400) @(negedge clk);
        if (mode == KEEP || mode == LATE_KEEP) begin
            decide(1'b0);
            for (t = 0; t < 4000 && delivered < target; t++) @(negedge clk);
            if (delivered < target) report_failure("kept packet never reached out_last");
            repeat (INTR_DLY + 4) @(negedge clk);
        end else if (mode == DROP) begin
            decide(1'b1);
            repeat (RST_CYCLES + 4) @(negedge clk);
        end else if (mode == NO_DECISION) begin
            for (t = 0; t < 4000 && !tlast_recover; t++) @(negedge clk);
            if (!tlast_recover) report_failure("no tlast_recover after a missing decision");
            @(negedge clk);
            recover_armed = 1'b0;
            repeat (RST_CYCLES + 4) @(negedge clk);
        end else begin
            // framer ignored this packet, so a request must stay unanswered
            decision_req = 1'b1;
            repeat (20) @(negedge clk);
            decision_req = 1'b0;
            repeat (4) @(negedge clk);
        end
    endtask

    task automatic finish_test(input string name, input int errors_before);
        if (errors == errors_before) tests_ok++;
        else tests_bad++;
        $display("test %s: %s", name, (errors == errors_before) ? "ok" : "FAILED");
    endtask

    initial begin
        int sum, e;
        {rstn, sig_valid, ht_sgi, ht_aggr, ht_aggr_last, ht_unsupport} = '0;
        {pkt_len, pkt_rate, rssi_half_db, tsf_val, byte_data} = '0;
        {byte_valid, byte_last, decision_req, decision_drop, us_tick} = '0;
        out_ready = 1'b1;
        recover_en = 1'b1;
        timeout_top = TIMEOUT_LONG;
        intr_delay = INTR_DLY;
        sum = 0;
        for (int i = 0; i < NPKT; i++) begin
            lens[i] = 1 + next_random() % 200;
            sum += lens[i];
        end
        watchdog_cycles = sum * 40 + 20000;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rstn = 1'b1;
        repeat (4) @(negedge clk);

        e = errors;
        repeat (4) send_packet(KEEP);
        finish_test("keep path", e);
        e = errors;
        send_packet(DROP);
        send_packet(KEEP);
        finish_test("drop path", e);
        e = errors;
        bp_on = 1'b1;
        repeat (4) send_packet(KEEP);
        bp_on = 1'b0;
        finish_test("back-pressure", e);
        e = errors;
        timeout_top = 100;
        recover_armed = 1'b1;
        send_packet(NO_DECISION);
        timeout_top = TIMEOUT_LONG;
        send_packet(KEEP);
        finish_test("timeout recovery", e);
        e = errors;
        recover_en = 1'b0;
        timeout_top = 20;
        send_packet(LATE_KEEP);
        recover_en = 1'b1;
        timeout_top = TIMEOUT_LONG;
        finish_test("recovery disabled", e);
        e = errors;
        send_packet(UNSUPPORTED);
        send_packet(KEEP);
        finish_test("unsupported packet", e);

        $display("tests passed: %0d, tests failed: %0d", tests_ok, tests_bad);
        if (errors == 0 && tests_bad == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

    // watchdog scaled by the total payload length
    initial begin
        wait (watchdog_cycles > 0);
        repeat (watchdog_cycles) @(posedge clk);
        $display("run did not finish within %0d cycles", watchdog_cycles);
        $display("Verification failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- design/rx_dma_top.sv
// rx dma framing subsystem with byte packer, packet framer and stream buffer toward the host dma
`default_nettype none

module rx_dma_top
    import rx_dma_pkg::*;
(
    input  logic                    clk,
    input  logic                    rstn,
    input  logic                    sig_valid,
    input  logic [LEN_W-1:0]        pkt_len,
    input  logic [7:0]              pkt_rate,
    input  logic [RSSI_W-1:0]       rssi_half_db,
    input  logic                    ht_sgi,
    input  logic                    ht_aggr,
    input  logic                    ht_aggr_last,
    input  logic                    ht_unsupport,
    input  logic [TSF_W-1:0]        tsf_val,
    input  logic [BYTE_W-1:0]       byte_data,
    input  logic                    byte_valid,
    input  logic                    byte_last,
    input  logic                    decision_req,
    input  logic                    decision_drop,
    output logic                    decision_ack,
    input  logic                    us_tick,
    input  logic                    recover_en,
    input  logic [TIMEOUT_W-1:0]    timeout_top,
    input  logic [INTR_DELAY_W-1:0] intr_delay,
    output logic [WORD_W-1:0]       out_data,
    output logic                    out_valid,
    output logic                    out_last,
    input  logic                    out_ready,
    output logic [WORDS_W-1:0]      num_words,
    output logic                    tlast_recover,
    output logic                    rx_pkt_intr
);

    logic [WORD_W-1:0] word_data;
    logic word_valid;
    logic [WORD_W-1:0] wr_data;
    logic wr_en;
    logic start;
    logic flush;
    logic last_done;

    rx_byte_packer u_packer (
        .clk(clk), .rstn(rstn),
        .byte_data(byte_data), .byte_valid(byte_valid), .byte_last(byte_last),
        .word_data(word_data), .word_valid(word_valid)
    );

    rx_pkt_framer u_framer (
        .clk(clk), .rstn(rstn),
        .sig_valid(sig_valid), .pkt_len(pkt_len), .pkt_rate(pkt_rate),
        .rssi_half_db(rssi_half_db), .ht_sgi(ht_sgi), .ht_aggr(ht_aggr),
        .ht_aggr_last(ht_aggr_last), .ht_unsupport(ht_unsupport), .tsf_val(tsf_val),
        .word_data(word_data), .word_valid(word_valid),
        .decision_req(decision_req), .decision_drop(decision_drop),
        .decision_ack(decision_ack),
        .us_tick(us_tick), .recover_en(recover_en), .timeout_top(timeout_top),
        .intr_delay(intr_delay),
        .wr_data(wr_data), .wr_en(wr_en), .start(start), .flush(flush),
        .num_words(num_words), .last_done(last_done),
        .tlast_recover(tlast_recover), .rx_pkt_intr(rx_pkt_intr)
    );

    rx_stream_buffer u_buffer (
        .clk(clk), .rstn(rstn),
        .wr_data(wr_data), .wr_en(wr_en), .start(start), .flush(flush),
        .num_words(num_words),
        .out_data(out_data), .out_valid(out_valid), .out_last(out_last),
        .out_ready(out_ready), .last_done(last_done)
    );

endmodule

`default_nettype wire

//--- design/rx_stream_buffer.sv
// word FIFO between the framer and the dma stream, released by start and emptied by flush
`default_nettype none

module rx_stream_buffer
    import rx_dma_pkg::*;
(
    input  logic               clk,
    input  logic               rstn,
    input  logic [WORD_W-1:0]  wr_data,
    input  logic               wr_en,
    input  logic               start,
    input  logic               flush,
    input  logic [WORDS_W-1:0] num_words,
    output logic [WORD_W-1:0]  out_data,
    output logic               out_valid,
    output logic               out_last,
    input  logic               out_ready,
    output logic               last_done
);

    logic [WORD_W-1:0] mem [BUF_DEPTH];
    logic [BUF_ADDR_W-1:0] wr_ptr;
    logic [BUF_ADDR_W-1:0] rd_ptr;
    logic [BUF_ADDR_W:0] fill;
    logic armed;
    logic [WORDS_W-1:0] words_lat;
    logic [WORDS_W-1:0] sent_cnt;
    logic empty;
    logic full;
    logic do_wr;
    logic do_rd;

    assign empty = (fill == '0);
    assign full = (fill == BUF_DEPTH);
    // writes during a flush belong to the discarded packet
    assign do_wr = wr_en && !flush;

    assign out_data = mem[rd_ptr];
    assign out_valid = armed && !empty && !flush;
    assign out_last = out_valid && (sent_cnt == words_lat - 1'b1);
    assign do_rd = out_valid && out_ready;
    assign last_done = do_rd && out_last;

    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn || flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            fill <= '0;
            armed <= 1'b0;
            sent_cnt <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_wr, do_rd})
                2'b10: fill <= fill + 1'b1;
                2'b01: fill <= fill - 1'b1;
                default: fill <= fill;
            endcase
            // arm for one packet, disarm on its last word
            if (start) begin
                armed <= 1'b1;
                sent_cnt <= '0;
            end else if (last_done) begin
                armed <= 1'b0;
                sent_cnt <= '0;
            end else if (do_rd) begin
                sent_cnt <= sent_cnt + 1'b1;
            end
        end
    end

    // packet length in words, taken at start
    always_ff @(posedge clk) begin
        if (start) begin
            words_lat <= num_words;
        end
    end

    a_no_write_full: assert property (
        @(posedge clk) disable iff (!rstn)
        do_wr |-> !full
    ) else $error("write into full stream buffer");

    a_hold_on_stall: assert property (
        @(posedge clk) disable iff (!rstn)
        out_valid && !out_ready && !flush |=> $stable(out_data) && $stable(out_last)
    ) else $error("stream word changed while stalled");

endmodule

`default_nettype wire

//--- design/rx_pkt_framer.sv
// puts tsf and info headers ahead of each payload and runs the keep/drop, recovery and irq flow
`default_nettype none

module rx_pkt_framer
    import rx_dma_pkg::*;
(
    input  logic                    clk,
    input  logic                    rstn,
    // signal field
    input  logic                    sig_valid,
    input  logic [LEN_W-1:0]        pkt_len,
    input  logic [7:0]              pkt_rate,
    input  logic [RSSI_W-1:0]       rssi_half_db,
    input  logic                    ht_sgi,
    input  logic                    ht_aggr,
    input  logic                    ht_aggr_last,
    input  logic                    ht_unsupport,
    input  logic [TSF_W-1:0]        tsf_val,
    // packed payload
    input  logic [WORD_W-1:0]       word_data,
    input  logic                    word_valid,
    // keep or drop from the upper layer
    input  logic                    decision_req,
    input  logic                    decision_drop,
    output logic                    decision_ack,
    // ticks and settings
    input  logic                    us_tick,
    input  logic                    recover_en,
    input  logic [TIMEOUT_W-1:0]    timeout_top,
    input  logic [INTR_DELAY_W-1:0] intr_delay,
    // stream buffer side
    output logic [WORD_W-1:0]       wr_data,
    output logic                    wr_en,
    output logic                    start,
    output logic                    flush,
    output logic [WORDS_W-1:0]      num_words,
    input  logic                    last_done,
    output logic                    tlast_recover,
    output logic                    rx_pkt_intr
);

    rx_state_t state;
    logic [WORD_W-1:0] info_word;
    logic [TIMEOUT_W-1:0] us_cnt;
    logic [$clog2(RST_CYCLES)-1:0] rst_cnt;
    logic [INTR_DELAY_W-1:0] intr_cnt;
    logic intr_busy;
    logic timeout_hit;
    logic us_step;
    logic take_decision;

    assign timeout_hit = recover_en && (us_cnt > timeout_top);
    // counter saturates so a disabled recovery cannot wrap around
    assign us_step = us_tick && (us_cnt != '1);
    assign take_decision = decision_req && !decision_ack;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state <= WAIT_PKT;
            wr_en <= 1'b0;
            start <= 1'b0;
            flush <= 1'b0;
            num_words <= '0;
            decision_ack <= 1'b0;
            tlast_recover <= 1'b0;
            us_cnt <= '0;
            rst_cnt <= '0;
        end else begin
            wr_en <= 1'b0;
            start <= 1'b0;
            tlast_recover <= 1'b0;
            // four-phase release
            if (!decision_req) begin
                decision_ack <= 1'b0;
            end
            case (state)
                WAIT_PKT: begin
                    us_cnt <= '0;
                    rst_cnt <= '0;
                    if (sig_valid && !ht_unsupport) begin
                        wr_en <= 1'b1;
                        num_words <= WORDS_W'(pkt_len[LEN_W-1:3])
                                   + WORDS_W'(pkt_len[2:0] != 3'd0)
                                   + WORDS_W'(HDR_WORDS);
                        state <= HDR_TSF;
                    end
                end
                HDR_TSF: begin
                    wr_en <= 1'b1;
                    state <= HDR_INFO;
                end
                HDR_INFO: begin
                    wr_en <= word_valid;
                    state <= WAIT_DECISION;
                end
                WAIT_DECISION: begin
                    wr_en <= word_valid;
                    if (timeout_hit) begin
                        tlast_recover <= 1'b1;
                        flush <= 1'b1;
                        state <= WAIT_FLUSH;
                    end else if (take_decision) begin
                        decision_ack <= 1'b1;
                        us_cnt <= '0;
                        if (decision_drop) begin
                            flush <= 1'b1;
                            state <= WAIT_FLUSH;
                        end else begin
                            start <= 1'b1;
                            state <= WAIT_LAST;
                        end
                    end else if (us_step) begin
                        us_cnt <= us_cnt + 1'b1;
                    end
                end
                WAIT_LAST: begin
                    wr_en <= word_valid;
                    // a completed stream wins over a timeout in the same cycle
                    if (last_done) begin
                        state <= WAIT_PKT;
                    end else if (timeout_hit) begin
                        tlast_recover <= 1'b1;
                        flush <= 1'b1;
                        state <= WAIT_FLUSH;
                    end else if (us_step) begin
                        us_cnt <= us_cnt + 1'b1;
                    end
                end
                WAIT_FLUSH: begin
                    rst_cnt <= rst_cnt + 1'b1;
                    if (rst_cnt == RST_CYCLES - 1) begin
                        flush <= 1'b0;
                        num_words <= '0;
                        state <= WAIT_PKT;
                    end
                end
                default: begin
                    state <= WAIT_PKT;
                end
            endcase
        end
    end

    // header and payload data path
    // payload is assumed to start well after the signal field, so HDR_TSF never sees a word
    always_ff @(posedge clk) begin
        if (state == WAIT_PKT && sig_valid) begin
            wr_data <= WORD_W'(tsf_val);
            info_word <= {8'd0, ht_aggr_last, ht_aggr, ht_sgi, pkt_rate[7], pkt_rate[3:0],
                          pkt_len, {(32 - RSSI_W){1'b0}}, rssi_half_db};
        end else if (state == HDR_TSF) begin
            wr_data <= info_word;
        end else if (word_valid) begin
            wr_data <= word_data;
        end
    end

    // delayed interrupt, restarted by every completed stream
    always_ff @(posedge clk) begin
        if (!rstn) begin
            intr_busy <= 1'b0;
            intr_cnt <= '0;
        end else if (last_done) begin
            intr_busy <= 1'b1;
            intr_cnt <= intr_delay;
        end else if (intr_busy) begin
            if (intr_cnt == '0) begin
                intr_busy <= 1'b0;
            end else begin
                intr_cnt <= intr_cnt - 1'b1;
            end
        end
    end

    assign rx_pkt_intr = intr_busy && (intr_cnt == '0);

    a_start_flush_excl: assert property (
        @(posedge clk) disable iff (!rstn)
        !(start && flush)
    ) else $error("start and flush raised together");

    a_ack_in_decision: assert property (
        @(posedge clk) disable iff (!rstn)
        $rose(decision_ack) |-> $past(state) == WAIT_DECISION
    ) else $error("decision_ack rose outside WAIT_DECISION");

endmodule

`default_nettype wire

//--- design/rx_byte_packer.sv
// gathers decoded payload bytes into little-endian 64-bit words for the packet framer
`default_nettype none

module rx_byte_packer
    import rx_dma_pkg::*;
(
    input  logic              clk,
    input  logic              rstn,
    input  logic [BYTE_W-1:0] byte_data,
    input  logic              byte_valid,
    input  logic              byte_last,
    output logic [WORD_W-1:0] word_data,
    output logic              word_valid
);

    logic [$clog2(BYTE_LANES)-1:0] lane;
    logic [WORD_W-1:0] acc;
    logic [WORD_W-1:0] next_word;
    logic word_done;

    // lanes below the current one come from the accumulator, lanes above stay zero
    always_comb begin
        next_word = '0;
        for (int i = 0; i < BYTE_LANES; i++) begin
            if (i < lane) begin
                next_word[i*BYTE_W +: BYTE_W] = acc[i*BYTE_W +: BYTE_W];
            end else if (i == lane) begin
                next_word[i*BYTE_W +: BYTE_W] = byte_data;
            end
        end
    end

    assign word_done = byte_valid && (byte_last || (lane == BYTE_LANES - 1));

    always_ff @(posedge clk) begin
        if (!rstn) begin
            lane <= '0;
            word_valid <= 1'b0;
        end else begin
            word_valid <= word_done;
            if (byte_valid) begin
                // restart at lane 0 for the next packet
                if (byte_last) begin
                    lane <= '0;
                end else begin
                    lane <= lane + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (byte_valid) begin
            acc <= next_word;
        end
        if (word_done) begin
            word_data <= next_word;
        end
    end

    // decoder leaves at least one idle cycle between bytes
    a_word_pulse_gap: assert property (
        @(posedge clk) disable iff (!rstn)
        word_valid |=> !word_valid
    ) else $error("packer emitted words in consecutive cycles");

endmodule

`default_nettype wire

//--- design/rx_dma_pkg.sv
// shared widths, buffer sizing and framer state encoding, imported by every rx dma module
`default_nettype none

package rx_dma_pkg;

    // stream and payload widths
    localparam int WORD_W = 64;
    localparam int BYTE_W = 8;
    localparam int BYTE_LANES = WORD_W / BYTE_W;

    // signal field widths
    localparam int LEN_W = 16;
    localparam int TSF_W = 64;
    localparam int RSSI_W = 11;

    // timeout counts microseconds, interrupt delay counts clocks
    localparam int TIMEOUT_W = 13;
    localparam int INTR_DELAY_W = 15;

    // words per packet, headers included
    localparam int WORDS_W = 14;

    // stream buffer
    localparam int BUF_DEPTH = 64;
    localparam int BUF_ADDR_W = 6;
    localparam int RST_CYCLES = 8;

    // tsf word and info word go out ahead of the payload
    localparam int HDR_WORDS = 2;

    typedef enum logic [2:0] {
        WAIT_PKT,
        HDR_TSF,
        HDR_INFO,
        WAIT_DECISION,
        WAIT_LAST,
        WAIT_FLUSH
    } rx_state_t;

endpackage

`default_nettype wire
